// ==== verilog/spongent_pkg.sv ====
// Spongent-88 shared definitions
package spongent_pkg;

    localparam int STATE_BITS    = 88;
    localparam int RATE_BITS     = 8;
    localparam int DIGEST_BITS   = 88;
    localparam int ROUNDS        = 45;
    localparam int SQUEEZE_BYTES = 11;

    localparam int LFSR_BITS                  = 6;
    localparam logic [LFSR_BITS-1:0] LFSR_INIT = 6'h05;
    localparam logic [LFSR_BITS-1:0] LFSR_TAPS = 6'h30; // x^6 + x^5 + 1.

    localparam logic [RATE_BITS-1:0] PAD_BYTE = 8'h80;

    // Word addresses of the register map.
    localparam logic [2:0] ADDR_DATA   = 3'd0;
    localparam logic [2:0] ADDR_CTRL   = 3'd1;
    localparam logic [2:0] ADDR_STATUS = 3'd2;
    localparam logic [2:0] ADDR_DIG0   = 3'd3;
    localparam logic [2:0] ADDR_DIG1   = 3'd4;
    localparam logic [2:0] ADDR_DIG2   = 3'd5;

    localparam logic [1:0] LOAD_KEEP   = 2'd0;
    localparam logic [1:0] LOAD_ABSORB = 2'd1;
    localparam logic [1:0] LOAD_PAD    = 2'd2;

    // Controller states.
    localparam logic [2:0] ST_IDLE         = 3'd0;
    localparam logic [2:0] ST_ABSORB_PERM  = 3'd1;
    localparam logic [2:0] ST_PAD_PERM     = 3'd2;
    localparam logic [2:0] ST_SQUEEZE_TAKE = 3'd3;
    localparam logic [2:0] ST_SQUEEZE_PERM = 3'd4;
    localparam logic [2:0] ST_FINISHED     = 3'd5;

    function automatic logic [3:0] sbox4(input logic [3:0] x);
        case (x)
            4'h0: return 4'hE;
            4'h1: return 4'hD;
            4'h2: return 4'hB;
            4'h3: return 4'h0;
            4'h4: return 4'h2;
            4'h5: return 4'h1;
            4'h6: return 4'h4;
            4'h7: return 4'hF;
            4'h8: return 4'h7;
            4'h9: return 4'hA;
            4'hA: return 4'h8;
            4'hB: return 4'h5;
            4'hC: return 4'h9;
            4'hD: return 4'hC;
            4'hE: return 4'h3;
            default: return 4'h6;
        endcase
    endfunction

    function automatic logic [STATE_BITS-1:0] p_layer(input logic [STATE_BITS-1:0] x);
        logic [STATE_BITS-1:0] y;
        y[STATE_BITS-1] = x[STATE_BITS-1]; // Top bit stays in place.
        for (int i = 0; i < STATE_BITS - 1; i++) begin
            y[(i * (STATE_BITS / 4)) % (STATE_BITS - 1)] = x[i];
        end
        return y;
    endfunction

endpackage

// ==== verilog/round_counter.sv ====
// Permutation round timer
module round_counter (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              perm_start,
    output logic [spongent_pkg::LFSR_BITS-1:0] lfsr_state,
    output logic                              perm_last,
    output logic                              running
);

    logic [$clog2(spongent_pkg::ROUNDS)-1:0] round_idx;
    logic [spongent_pkg::LFSR_BITS-1:0]      lfsr_next;

    // Shift left with feedback from the tapped bits.
    assign lfsr_next = {lfsr_state[spongent_pkg::LFSR_BITS-2:0],
                        ^(lfsr_state & spongent_pkg::LFSR_TAPS)};

    assign perm_last = running && (int'(round_idx) == spongent_pkg::ROUNDS - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            running    <= 1'b0;
            round_idx  <= '0;
            lfsr_state <= spongent_pkg::LFSR_INIT;
        end else if (perm_start) begin
            running    <= 1'b1;
            round_idx  <= '0;
            lfsr_state <= spongent_pkg::LFSR_INIT;
        end else if (running) begin
            round_idx  <= round_idx + 1'b1;
            lfsr_state <= lfsr_next;
            if (perm_last) begin
                running <= 1'b0; // Last round applied this cycle.
            end
        end
    end

endmodule

// ==== verilog/spongent_round.sv ====
// Spongent permutation datapath
module spongent_round (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                perm_start,
    input  logic                                running,
    input  logic [1:0]                          load_sel,
    input  logic [spongent_pkg::RATE_BITS-1:0]  msg_byte,
    input  logic [spongent_pkg::LFSR_BITS-1:0]  lfsr_state,
    input  logic                                clear,
    output logic [spongent_pkg::STATE_BITS-1:0] state
);

    logic [spongent_pkg::LFSR_BITS-1:0]  lfsr_rev;
    logic [spongent_pkg::STATE_BITS-1:0] rc_state;
    logic [spongent_pkg::STATE_BITS-1:0] sbox_state;
    logic [spongent_pkg::STATE_BITS-1:0] round_out;
    logic [spongent_pkg::STATE_BITS-1:0] load_val;

    assign lfsr_rev = {<<{lfsr_state}};

    // Round constant at both ends, then S-box layer and bit permutation.
    always_comb begin
        rc_state = state;
        rc_state[spongent_pkg::LFSR_BITS-1:0] =
            state[spongent_pkg::LFSR_BITS-1:0] ^ lfsr_state;
        rc_state[spongent_pkg::STATE_BITS-1 -: spongent_pkg::LFSR_BITS] =
            state[spongent_pkg::STATE_BITS-1 -: spongent_pkg::LFSR_BITS] ^ lfsr_rev;
        for (int n = 0; n < spongent_pkg::STATE_BITS / 4; n++) begin
            sbox_state[4*n +: 4] = spongent_pkg::sbox4(rc_state[4*n +: 4]);
        end
        round_out = spongent_pkg::p_layer(sbox_state);
    end

    // Rate block sits in the top byte.
    always_comb begin
        load_val = state;
        case (load_sel)
            spongent_pkg::LOAD_ABSORB: begin
                load_val[spongent_pkg::STATE_BITS-1 -: spongent_pkg::RATE_BITS] =
                    state[spongent_pkg::STATE_BITS-1 -: spongent_pkg::RATE_BITS] ^ msg_byte;
            end
            spongent_pkg::LOAD_PAD: begin
                load_val[spongent_pkg::STATE_BITS-1 -: spongent_pkg::RATE_BITS] =
                    state[spongent_pkg::STATE_BITS-1 -: spongent_pkg::RATE_BITS]
                    ^ spongent_pkg::PAD_BYTE;
            end
            default: load_val = state;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            state <= '0;
        end else if (perm_start) begin
            state <= load_val;
        end else if (running) begin
            state <= round_out; // One round per cycle.
        end
    end

endmodule

// ==== verilog/sponge_ctrl.sv ====
// Sponge sequencing FSM
module sponge_ctrl (
    input  logic       clk,
    input  logic       rst,
    input  logic       absorb_req,
    input  logic       finish_req,
    input  logic       clear_req,
    input  logic       perm_last,
    output logic       perm_start,
    output logic [1:0] load_sel,
    output logic       take,
    output logic       busy,
    output logic       done,
    output logic       clear
);

    logic [2:0] state_q;
    logic [2:0] state_d;
    logic [3:0] take_cnt;
    logic       last_take;

    assign last_take = int'(take_cnt) == spongent_pkg::SQUEEZE_BYTES - 1;
    assign clear     = clear_req;
    assign done      = state_q == spongent_pkg::ST_FINISHED;

    // A request seen in idle counts as busy at once.
    always_comb begin
        case (state_q)
            spongent_pkg::ST_IDLE:         busy = absorb_req || finish_req;
            spongent_pkg::ST_ABSORB_PERM:  busy = 1'b1;
            spongent_pkg::ST_PAD_PERM:     busy = 1'b1;
            spongent_pkg::ST_SQUEEZE_TAKE: busy = 1'b1;
            spongent_pkg::ST_SQUEEZE_PERM: busy = 1'b1;
            default:                       busy = 1'b0;
        endcase
    end

    always_comb begin
        state_d    = state_q;
        perm_start = 1'b0;
        load_sel   = spongent_pkg::LOAD_KEEP;
        take       = 1'b0;
        case (state_q)
            spongent_pkg::ST_IDLE: begin
                if (absorb_req) begin
                    perm_start = 1'b1;
                    load_sel   = spongent_pkg::LOAD_ABSORB;
                    state_d    = spongent_pkg::ST_ABSORB_PERM;
                end else if (finish_req) begin
                    perm_start = 1'b1;
                    load_sel   = spongent_pkg::LOAD_PAD;
                    state_d    = spongent_pkg::ST_PAD_PERM;
                end
            end
            spongent_pkg::ST_ABSORB_PERM: begin
                if (perm_last) begin
                    state_d = spongent_pkg::ST_IDLE;
                end
            end
            spongent_pkg::ST_PAD_PERM: begin
                if (perm_last) begin
                    state_d = spongent_pkg::ST_SQUEEZE_TAKE;
                end
            end
            spongent_pkg::ST_SQUEEZE_TAKE: begin
                take = 1'b1;
                if (last_take) begin
                    state_d = spongent_pkg::ST_FINISHED; // No permutation after the last byte.
                end else begin
                    perm_start = 1'b1;
                    state_d    = spongent_pkg::ST_SQUEEZE_PERM;
                end
            end
            spongent_pkg::ST_SQUEEZE_PERM: begin
                if (perm_last) begin
                    state_d = spongent_pkg::ST_SQUEEZE_TAKE;
                end
            end
            spongent_pkg::ST_FINISHED: state_d = spongent_pkg::ST_FINISHED;
            default: state_d = spongent_pkg::ST_IDLE;
        endcase
        if (clear_req) begin
            state_d    = spongent_pkg::ST_IDLE;
            perm_start = 1'b0;
            take       = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= spongent_pkg::ST_IDLE;
            take_cnt <= '0;
        end else begin
            state_q <= state_d;
            if (clear_req) begin
                take_cnt <= '0;
            end else if (take) begin
                take_cnt <= take_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/digest_shift.sv ====
// Squeezed digest collector
module digest_shift (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 clear,
    input  logic                                 take,
    input  logic [spongent_pkg::RATE_BITS-1:0]   top_byte,
    output logic [spongent_pkg::DIGEST_BITS-1:0] digest
);

    // First byte out ends up in the top byte.
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            digest <= '0;
        end else if (take) begin
            digest <= {digest[spongent_pkg::DIGEST_BITS-spongent_pkg::RATE_BITS-1:0],
                       top_byte};
        end
    end

endmodule

// ==== verilog/wb_regs.sv ====
// Wishbone register slave
module wb_regs (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 cyc,
    input  logic                                 stb,
    input  logic                                 we,
    input  logic [2:0]                           adr,
    input  logic [31:0]                          dat_w,
    output logic [31:0]                          dat_r,
    output logic                                 ack,
    input  logic                                 busy,
    input  logic                                 done,
    input  logic [spongent_pkg::DIGEST_BITS-1:0] digest,
    output logic                                 absorb_req,
    output logic                                 finish_req,
    output logic                                 clear_req,
    output logic [spongent_pkg::RATE_BITS-1:0]   msg_byte
);

    logic        req;
    logic        is_cmd;
    logic        cmd_accept;
    logic        plain_ack;
    logic [31:0] rd_word;

    assign req    = cyc && stb && !ack; // Ack blocks a second accept of the same access.
    assign is_cmd = (adr == spongent_pkg::ADDR_DATA) || (adr == spongent_pkg::ADDR_CTRL);

    assign cmd_accept = req && we && is_cmd && !busy;
    assign plain_ack  = req && !(we && is_cmd);

    always_comb begin
        case (adr)
            spongent_pkg::ADDR_STATUS: rd_word = {30'd0, done, busy};
            spongent_pkg::ADDR_DIG0:   rd_word = {8'd0, digest[87:64]};
            spongent_pkg::ADDR_DIG1:   rd_word = digest[63:32];
            spongent_pkg::ADDR_DIG2:   rd_word = digest[31:0];
            default:                   rd_word = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack        <= 1'b0;
            absorb_req <= 1'b0;
            finish_req <= 1'b0;
            clear_req  <= 1'b0;
        end else begin
            ack        <= cmd_accept || plain_ack;
            absorb_req <= cmd_accept && (adr == spongent_pkg::ADDR_DATA);
            finish_req <= cmd_accept && (adr == spongent_pkg::ADDR_CTRL) && dat_w[0];
            clear_req  <= cmd_accept && (adr == spongent_pkg::ADDR_CTRL) && dat_w[1];
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_accept && (adr == spongent_pkg::ADDR_DATA)) begin
            msg_byte <= dat_w[7:0];
        end
        if (req && !we) begin
            dat_r <= rd_word;
        end
    end

endmodule

// ==== verilog/spongent_wb_top.sv ====
// Spongent-88 Wishbone core
module spongent_wb_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [2:0]  adr,
    input  logic [31:0] dat_w,
    output logic [31:0] dat_r,
    output logic        ack
);

    logic                                 busy;
    logic                                 done;
    logic                                 absorb_req;
    logic                                 finish_req;
    logic                                 clear_req;
    logic [spongent_pkg::RATE_BITS-1:0]   msg_byte;
    logic                                 perm_start;
    logic [1:0]                           load_sel;
    logic                                 take;
    logic                                 clear;
    logic                                 perm_last;
    logic                                 running;
    logic [spongent_pkg::LFSR_BITS-1:0]   lfsr_state;
    logic [spongent_pkg::STATE_BITS-1:0]  state;
    logic [spongent_pkg::DIGEST_BITS-1:0] digest;

    wb_regs u_regs (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .dat_r(dat_r), .ack(ack), .busy(busy), .done(done),
        .digest(digest), .absorb_req(absorb_req), .finish_req(finish_req),
        .clear_req(clear_req), .msg_byte(msg_byte)
    );

    sponge_ctrl u_ctrl (
        .clk(clk), .rst(rst), .absorb_req(absorb_req), .finish_req(finish_req),
        .clear_req(clear_req), .perm_last(perm_last), .perm_start(perm_start),
        .load_sel(load_sel), .take(take), .busy(busy), .done(done), .clear(clear)
    );

    round_counter u_rounds (
        .clk(clk), .rst(rst), .perm_start(perm_start), .lfsr_state(lfsr_state),
        .perm_last(perm_last), .running(running)
    );

    spongent_round u_perm (
        .clk(clk), .rst(rst), .perm_start(perm_start), .running(running),
        .load_sel(load_sel), .msg_byte(msg_byte), .lfsr_state(lfsr_state),
        .clear(clear), .state(state)
    );

    digest_shift u_digest (
        .clk(clk), .rst(rst), .clear(clear), .take(take),
        .top_byte(state[spongent_pkg::STATE_BITS-1 -: spongent_pkg::RATE_BITS]),
        .digest(digest)
    );

endmodule

// ==== verif/spongent_assert.sv ====
// Bus and timing checks
module spongent_assert (
    input logic       clk,
    input logic       rst,
    input logic       cyc,
    input logic       stb,
    input logic       we,
    input logic [2:0] adr,
    input logic       ack,
    input logic       busy,
    input logic       done
);

    int unsigned fail_count = 0;
    logic        data_accept;

    // DATA write taken by the core in this cycle.
    assign data_accept = cyc && stb && we && !ack && !busy && !done
                         && (adr == spongent_pkg::ADDR_DATA);

    reset_quiet: assert property (@(posedge clk) $past(rst) |-> !busy && !done)
        else begin
            fail_count++;
            $error("busy or done high during or right after reset");
        end

    ack_in_cycle: assert property (@(posedge clk) disable iff (rst) ack |-> cyc && stb)
        else begin
            fail_count++;
            $error("ack without cyc and stb");
        end

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else begin
            fail_count++;
            $error("ack high for two cycles");
        end

    busy_timing: assert property (@(posedge clk) disable iff (rst)
                                  data_accept |-> ##47 $fell(busy))
        else begin
            fail_count++;
            $error("busy did not fall 47 cycles after a data write");
        end

endmodule

// ==== verif/spongent_ref.svh ====
// Spongent-88 reference model
`ifndef SPONGENT_REF_SVH
`define SPONGENT_REF_SVH

typedef logic [7:0] byte_queue_t[$];

// Nibble x holds S(x).
localparam logic [63:0] REF_SBOX = 64'h63C9_58A7_F412_0BDE;

function automatic logic [5:0] ref_lfsr_step(input logic [5:0] l);
    return {l[4:0], l[5] ^ l[4]}; // x^6 + x^5 + 1.
endfunction

function automatic logic [87:0] ref_round(input logic [87:0] s, input logic [5:0] rc);
    logic [87:0] t;
    logic [87:0] u;
    t = s;
    for (int j = 0; j < 6; j++) begin
        t[j]      = t[j] ^ rc[j];
        t[87 - j] = t[87 - j] ^ rc[j]; // Mirrored constant at the top.
    end
    for (int n = 0; n < 22; n++) begin
        t[4*n +: 4] = REF_SBOX[int'(t[4*n +: 4]) * 4 +: 4];
    end
    u[87] = t[87];
    for (int i = 0; i < 87; i++) begin
        u[(i * 22) % 87] = t[i];
    end
    return u;
endfunction

function automatic logic [87:0] ref_permute(input logic [87:0] s);
    logic [5:0]  lfsr;
    logic [87:0] r;
    lfsr = 6'h05;
    r    = s;
    for (int k = 0; k < 45; k++) begin
        r    = ref_round(r, lfsr);
        lfsr = ref_lfsr_step(lfsr);
    end
    return r;
endfunction

function automatic logic [87:0] ref_digest(input byte_queue_t msg);
    logic [87:0] s;
    logic [87:0] d;
    s = '0;
    d = '0;
    foreach (msg[i]) begin
        s[87:80] = s[87:80] ^ msg[i];
        s        = ref_permute(s);
    end
    s[87:80] = s[87:80] ^ 8'h80; // Padding block.
    s        = ref_permute(s);
    for (int k = 0; k < 11; k++) begin
        d = {d[79:0], s[87:80]};
        if (k < 10) begin
            s = ref_permute(s);
        end
    end
    return d;
endfunction

`endif

// ==== verif/spongent_tb.sv ====
// Spongent-88 Wishbone testbench
module spongent_tb;

    localparam int TIMEOUT_CYCLES = 2000;

    logic        clk;
    logic        rst;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [2:0]  adr;
    logic [31:0] dat_w;
    logic [31:0] dat_r;
    logic        ack;

    `include "spongent_ref.svh"

    spongent_wb_top dut (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .dat_r(dat_r), .ack(ack)
    );

    bind spongent_wb_top spongent_assert u_assert (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .ack(ack), .busy(busy), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(negedge clk) begin
        if (dut.u_assert.fail_count != 0) begin
            $display("a bound protocol or timing assertion failed");
            $display("sim failed");
            $fatal(1);
        end
    end

    task automatic report_error(input string what);
        $display("error at time %0t: %s", $time, what);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at time %0t: %s", $time, what);
        $display("sim failed");
        $fatal(1);
    endtask

    // Starts and ends 5 units after a rising edge.
    task automatic bus_cycle(input logic write, input logic [2:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output int cycles);
        int   n;
        logic ack_seen;
        cyc      = 1'b1;
        stb      = 1'b1;
        we       = write;
        adr      = addr;
        dat_w    = wdata;
        n        = 0;
        ack_seen = 1'b0;
        while (!ack_seen) begin
            @(negedge clk);
            n++;
            ack_seen = ack;
            if (!ack_seen && n >= TIMEOUT_CYCLES) begin
                report_timeout($sformatf("no ack for access to register %0d", addr));
            end
        end
        rdata  = dat_r;
        cycles = n;
        @(posedge clk);
        #5;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic write_reg(input logic [2:0] addr, input logic [31:0] wdata,
                             output int cycles);
        logic [31:0] ignored;
        bus_cycle(1'b1, addr, wdata, ignored, cycles);
    endtask

    task automatic read_reg(input logic [2:0] addr, output logic [31:0] rdata);
        int cycles;
        bus_cycle(1'b0, addr, 32'd0, rdata, cycles);
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        assert (got == exp)
            else report_error($sformatf("%s read %h, expected %h", what, got, exp));
    endtask

    task automatic wait_done();
        logic [31:0] status;
        int          waited;
        waited = 0;
        status = 32'd0;
        while (!status[1]) begin
            read_reg(spongent_pkg::ADDR_STATUS, status);
            waited += 2;
            if (!status[1] && waited >= TIMEOUT_CYCLES) begin
                report_timeout("done never rose after finish");
            end
        end
    endtask

    task automatic check_idle(input string label);
        logic [31:0] word;
        read_reg(spongent_pkg::ADDR_STATUS, word);
        check_word(word, 32'd0, {label, " STATUS"});
        read_reg(spongent_pkg::ADDR_DIG0, word);
        check_word(word, 32'd0, {label, " DIG0"});
        read_reg(spongent_pkg::ADDR_DIG1, word);
        check_word(word, 32'd0, {label, " DIG1"});
        read_reg(spongent_pkg::ADDR_DIG2, word);
        check_word(word, 32'd0, {label, " DIG2"});
    endtask

    task automatic clear_core();
        int cycles;
        write_reg(spongent_pkg::ADDR_CTRL, 32'd2, cycles);
        check_idle("after clear");
    endtask

    task automatic finish_and_check(input byte_queue_t msg, input string label);
        logic [87:0] expected;
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] w2;
        int          cycles;
        expected = ref_digest(msg);
        write_reg(spongent_pkg::ADDR_CTRL, 32'd1, cycles);
        wait_done();
        read_reg(spongent_pkg::ADDR_DIG0, w0);
        read_reg(spongent_pkg::ADDR_DIG1, w1);
        read_reg(spongent_pkg::ADDR_DIG2, w2);
        check_word(w0, {8'd0, expected[87:64]}, {label, " DIG0"});
        check_word(w1, expected[63:32], {label, " DIG1"});
        check_word(w2, expected[31:0], {label, " DIG2"});
    endtask

    task automatic hash_and_check(input byte_queue_t msg, input string label);
        int cycles;
        foreach (msg[i]) begin
            write_reg(spongent_pkg::ADDR_DATA, {24'd0, msg[i]}, cycles);
        end
        finish_and_check(msg, label);
    endtask

    task automatic random_message(input int len, output byte_queue_t msg);
        msg.delete();
        repeat (len) begin
            msg.push_back(8'($urandom));
        end
    endtask

    initial begin
        byte_queue_t msg;
        byte_queue_t repeat_msg;
        int          lengths[3];
        int          cycles;
        int unsigned seed_val;
        rst      = 1'b1;
        cyc      = 1'b0;
        stb      = 1'b0;
        we       = 1'b0;
        adr      = 3'd0;
        dat_w    = 32'd0;
        seed_val = $urandom(40);
        lengths  = '{1, 5, 20};
        repeat (4) @(posedge clk);
        #5;
        rst = 1'b0;

        check_idle("after reset");

        msg.delete();
        hash_and_check(msg, "empty message");
        clear_core();

        foreach (lengths[k]) begin
            random_message(lengths[k], msg);
            hash_and_check(msg, $sformatf("%0d byte message", lengths[k]));
            clear_core();
            if (lengths[k] == 5) begin
                repeat_msg = msg;
            end
        end

        // Second write stalls until the first permutation ends.
        random_message(2, msg);
        write_reg(spongent_pkg::ADDR_DATA, {24'd0, msg[0]}, cycles);
        write_reg(spongent_pkg::ADDR_DATA, {24'd0, msg[1]}, cycles);
        assert (cycles == 47)
            else report_error($sformatf("second data write acked after %0d cycles, expected 47",
                                        cycles));
        finish_and_check(msg, "back-to-back pair");
        clear_core();

        hash_and_check(repeat_msg, "first run");
        clear_core();
        hash_and_check(repeat_msg, "second run");

        if (dut.u_assert.fail_count == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("a bound protocol or timing assertion failed");
            $display("sim failed");
            $fatal(1);
        end
    end

endmodule

// ==== spongent_wb.f ====
+incdir+verif
verilog/spongent_pkg.sv
verilog/round_counter.sv
verilog/spongent_round.sv
verilog/sponge_ctrl.sv
verilog/digest_shift.sv
verilog/wb_regs.sv
verilog/spongent_wb_top.sv
verif/spongent_assert.sv
verif/spongent_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the Spongent-88 Wishbone testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal \
    --top-module spongent_tb -f spongent_wb.f \
    -o spongent_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/spongent_sim +verilator+error+limit+10 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" sim.log; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0
